//--- vlog.f
+incdir+design
design/mmio_pkg.sv
design/chan_if.sv
design/mmio_router.sv
design/mem_bus_master.sv
design/periph_bridge.sv
design/mmio_top.sv
tb/tb_target_models.sv
tb/tb_mmio_top.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run, pass only when the simulation prints the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mmio_top -f vlog.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "TEST PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tb/tb_mmio_top.sv
`include "mmio_cfg.svh"

module tb_mmio_top;
    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_ROWS        = 18;
    localparam int HOLD_CYCLES     = 6; // forced spi busy length
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + RESET_CYCLES;
    localparam int POISON_ADDR     = 700;

    // expected side effect of a row
    localparam logic [2:0] K_NONE     = 3'd0; // no strobe and no enable
    localparam logic [2:0] K_MEM      = 3'd1; // one memory strobe
    localparam logic [2:0] K_CMD      = 3'd2; // one spi command enable
    localparam logic [2:0] K_CMD_BUSY = 3'd3; // command enable after a forced busy hold
    localparam logic [2:0] K_PARAM    = 3'd4; // one spi parameter enable
    localparam logic [2:0] K_TOUCH    = 3'd5; // i2c pulse of wdata before the read

    typedef struct packed {
        logic                    wr;
        logic [`MMIO_DATA_W-1:0] addr;
        logic [`MMIO_DATA_W-1:0] wdata;
        logic [`MMIO_DATA_W-1:0] exp;
        logic [2:0]              kind;
    } row_t;

    logic                    clk;
    logic                    nRst;
    logic                    host_req_i;
    logic                    host_write_i;
    logic [`MMIO_DATA_W-1:0] host_addr_i;
    logic [`MMIO_DATA_W-1:0] host_wdata_i;
    logic                    host_ack_o;
    logic [`MMIO_DATA_W-1:0] host_rdata_o;
    logic                    mem_read_o;
    logic                    mem_write_o;
    logic [`MMIO_DATA_W-1:0] mem_addr_o;
    logic [`MMIO_DATA_W-1:0] mem_wdata_o;
    logic [`MMIO_DATA_W-1:0] mem_rdata_i;
    logic                    mem_busy_i;
    logic                    spi_busy_i;
    logic [`MMIO_DATA_W-1:0] spi_data_o;
    logic                    spi_comm_enable_o;
    logic                    spi_param_enable_o;
    logic [`MMIO_DATA_W-1:0] i2c_xy_i;
    logic                    i2c_done_i;
    logic                    spi_hold;   // forces spi busy
    logic                    i2c_fire;
    logic [`MMIO_DATA_W-1:0] i2c_coord;

    row_t                    rows [NUM_ROWS];
    int                      err_cnt   = 0;
    int                      proto_cnt = 0;
    // running pulse counts that each row diffs
    int                      rd_cnt    = 0;
    int                      wr_cnt    = 0;
    int                      cmd_cnt   = 0;
    int                      par_cnt   = 0;
    logic [`MMIO_DATA_W-1:0] spi_last  = '0;

    mmio_top mmio_top_i (.*);

    mem_model #(.POISON_ADDR(POISON_ADDR)) mem_m (
        .clk(clk), .nRst(nRst), .read_i(mem_read_o), .write_i(mem_write_o),
        .addr_i(mem_addr_o), .wdata_i(mem_wdata_o), .rdata_o(mem_rdata_i), .busy_o(mem_busy_i)
    );
    spi_model spi_m (
        .clk(clk), .nRst(nRst), .comm_enable_i(spi_comm_enable_o),
        .hold_i(spi_hold), .busy_o(spi_busy_i)
    );
    i2c_model i2c_m (
        .clk(clk), .nRst(nRst), .fire_i(i2c_fire), .coord_i(i2c_coord),
        .done_o(i2c_done_i), .xy_o(i2c_xy_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // strobe and enable monitor
    always @(posedge clk) begin
        if (mem_read_o) rd_cnt <= rd_cnt + 1;
        if (mem_write_o) wr_cnt <= wr_cnt + 1;
        if (spi_comm_enable_o) cmd_cnt <= cmd_cnt + 1;
        if (spi_param_enable_o) par_cnt <= par_cnt + 1;
        if (spi_comm_enable_o || spi_param_enable_o) spi_last <= spi_data_o;
        if (spi_comm_enable_o && spi_busy_i) begin
            proto_cnt <= proto_cnt + 1;
            $display("SPI command enable raised while SPI was busy at %0t", $time);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    // one four-phase host access plus its side-effect checks
    task automatic apply_row(input row_t r);
        int                      rd0;
        int                      wr0;
        int                      cmd0;
        int                      par0;
        int                      exp_rd;
        int                      exp_wr;
        int                      exp_cmd;
        int                      exp_par;
        logic [`MMIO_DATA_W-1:0] got;
        exp_rd  = (r.kind == K_MEM && !r.wr) ? 1 : 0;
        exp_wr  = (r.kind == K_MEM && r.wr) ? 1 : 0;
        exp_cmd = (r.kind == K_CMD || r.kind == K_CMD_BUSY) ? 1 : 0;
        exp_par = (r.kind == K_PARAM) ? 1 : 0;
        @(posedge clk);
        #1;
        if (r.kind == K_TOUCH) begin
            i2c_fire  = 1'b1; // coordinate rides in the wdata column
            i2c_coord = r.wdata;
            @(posedge clk);
            #1;
            i2c_fire = 1'b0;
            @(posedge clk);
            #1;
        end
        rd0  = rd_cnt;
        wr0  = wr_cnt;
        cmd0 = cmd_cnt;
        par0 = par_cnt;
        if (r.kind == K_CMD_BUSY) spi_hold = 1'b1;
        host_req_i   = 1'b1;
        host_write_i = r.wr;
        host_addr_i  = r.addr;
        host_wdata_i = r.wdata;
        if (r.kind == K_CMD_BUSY) begin
            repeat (HOLD_CYCLES) @(posedge clk); // command must stay parked
            #1;
            spi_hold = 1'b0;
        end
        @(posedge clk);
        #1;
        while (!host_ack_o) begin
            @(posedge clk);
            #1;
        end
        got = host_rdata_o; // valid while ack high
        host_req_i = 1'b0;
        @(posedge clk);
        #1;
        while (host_ack_o) begin
            @(posedge clk);
            #1;
        end
        check_value("host_rdata_o", got, r.exp);
        check_value("mem_read_o pulses", rd_cnt - rd0, exp_rd);
        check_value("mem_write_o pulses", wr_cnt - wr0, exp_wr);
        check_value("spi_comm_enable_o pulses", cmd_cnt - cmd0, exp_cmd);
        check_value("spi_param_enable_o pulses", par_cnt - par0, exp_par);
        if (exp_cmd + exp_par != 0) check_value("spi_data_o", spi_last, r.wdata);
    endtask

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: a host access did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h1537));
        clk          = 1'b0;
        nRst         = 1'b0;
        host_req_i   = 1'b0;
        host_write_i = 1'b0;
        host_addr_i  = '0;
        host_wdata_i = '0;
        spi_hold     = 1'b0;
        i2c_fire     = 1'b0;
        i2c_coord    = '0;

        // wr, addr, wdata, expected rdata, side effect
        rows[0]  = '{1'b1, 32'd5, 32'h1234_5678, 32'h0, K_MEM};
        rows[1]  = '{1'b0, 32'd5, 32'h0, 32'h1234_5678, K_MEM};
        rows[2]  = '{1'b1, 32'd6, 32'hCAFE_F00D, 32'h0, K_MEM};
        rows[3]  = '{1'b0, 32'd5, 32'h0, 32'h1234_5678, K_MEM}; // first word intact
        rows[4]  = '{1'b0, 32'd6, 32'h0, 32'hCAFE_F00D, K_MEM};
        rows[5]  = '{1'b0, 32'd2047, 32'h0, 32'hF800_07FF, K_MEM}; // fill pattern
        rows[6]  = '{1'b0, POISON_ADDR, 32'h0, 32'h0, K_MEM};     // poison reads zero
        rows[7]  = '{1'b0, `MMIO_I2C_ADDR, 32'h0, 32'h0, K_NONE}; // nothing captured yet
        rows[8]  = '{1'b0, `MMIO_I2C_ADDR, 32'h0064_0032, 32'h0064_0032, K_TOUCH};
        rows[9]  = '{1'b1, `MMIO_SPI_CMD_ADDR, 32'h0000_00A1, 32'h0, K_CMD_BUSY};
        rows[10] = '{1'b1, `MMIO_SPI_CMD_ADDR, 32'h0000_00A2, 32'h0, K_CMD};
        rows[11] = '{1'b1, `MMIO_SPI_CMD_ADDR, 32'h0000_00A3, 32'h0, K_CMD};
        rows[12] = '{1'b1, `MMIO_SPI_PARAM_ADDR, 32'h0000_55AA, 32'h0, K_PARAM};
        rows[13] = '{1'b1, `MMIO_I2C_ADDR, 32'h1111_2222, 32'h0, K_NONE};
        rows[14] = '{1'b1, 32'd500000, 32'hDEAD_BEEF, 32'h0, K_NONE}; // unmapped write
        rows[15] = '{1'b0, `MMIO_I2C_ADDR, 32'h0, 32'h0064_0032, K_NONE}; // capture kept
        rows[16] = '{1'b0, 32'd4096, 32'h0, 32'h0, K_NONE};        // unmapped read
        rows[17] = '{1'b0, `MMIO_SPI_CMD_ADDR, 32'h0, 32'h0, K_NONE};

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nRst = 1'b1;
        check_value("outputs after reset",
                    {27'b0, host_ack_o, mem_read_o, mem_write_o,
                     spi_comm_enable_o, spi_param_enable_o}, 32'h0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
        end
        repeat (4) @(posedge clk);

        $display("summary: %0d value errors, %0d protocol errors", err_cnt, proto_cnt);
        if (err_cnt == 0 && proto_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end
endmodule

//--- tb/tb_target_models.sv
`include "mmio_cfg.svh"

// data memory with a random busy window after each strobe
module mem_model #(
    parameter int POISON_ADDR = 700
) (
    input  logic                    clk,
    input  logic                    nRst,
    input  logic                    read_i,
    input  logic                    write_i,
    input  logic [`MMIO_DATA_W-1:0] addr_i,
    input  logic [`MMIO_DATA_W-1:0] wdata_i,
    output logic [`MMIO_DATA_W-1:0] rdata_o,
    output logic                    busy_o
);
    logic [`MMIO_DATA_W-1:0] mem [0:`MMIO_MEM_WORDS-1];
    int unsigned             left; // busy cycles still to go

    initial begin
        for (int i = 0; i < `MMIO_MEM_WORDS; i++) begin
            mem[i] = {~i[15:0], i[15:0]}; // address in both halves
        end
        mem[POISON_ADDR] = `MMIO_POISON;
    end

    always @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            busy_o  <= 1'b0;
            left    <= 0;
            rdata_o <= '0;
        end else if (read_i || write_i) begin
            left   <= $urandom_range(4, 1); // 1..4 busy cycles
            busy_o <= 1'b1;
            if (write_i) begin
                mem[addr_i[10:0]] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i[10:0]]; // held until next read
            end
        end else if (left > 1) begin
            left <= left - 1;
        end else begin
            left   <= 0;
            busy_o <= 1'b0;
        end
    end
endmodule

// spi controller busy after each command, plus a forced hold from the testbench
module spi_model (
    input  logic clk,
    input  logic nRst,
    input  logic comm_enable_i,
    input  logic hold_i,
    output logic busy_o
);
    int unsigned left;

    assign busy_o = hold_i | (left != 0);

    always @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            left <= 0;
        end else if (comm_enable_i) begin
            left <= $urandom_range(5, 0); // may be zero
        end else if (left != 0) begin
            left <= left - 1;
        end
    end
endmodule

// touch sensor, one done pulse per fire request
module i2c_model (
    input  logic                    clk,
    input  logic                    nRst,
    input  logic                    fire_i,
    input  logic [`MMIO_DATA_W-1:0] coord_i,
    output logic                    done_o,
    output logic [`MMIO_DATA_W-1:0] xy_o
);
    always @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            done_o <= 1'b0;
            xy_o   <= '0;
        end else begin
            done_o <= fire_i;
            if (fire_i) xy_o <= coord_i;
        end
    end
endmodule

//--- design/mmio_top.sv
`include "mmio_cfg.svh"

module mmio_top (
    input  logic                    clk,
    input  logic                    nRst,
    // host
    input  logic                    host_req_i,
    input  logic                    host_write_i,
    input  logic [`MMIO_DATA_W-1:0] host_addr_i,
    input  logic [`MMIO_DATA_W-1:0] host_wdata_i,
    output logic                    host_ack_o,
    output logic [`MMIO_DATA_W-1:0] host_rdata_o,
    // data memory
    output logic                    mem_read_o,
    output logic                    mem_write_o,
    output logic [`MMIO_DATA_W-1:0] mem_addr_o,
    output logic [`MMIO_DATA_W-1:0] mem_wdata_o,
    input  logic [`MMIO_DATA_W-1:0] mem_rdata_i,
    input  logic                    mem_busy_i,
    // spi
    input  logic                    spi_busy_i,
    output logic [`MMIO_DATA_W-1:0] spi_data_o,
    output logic                    spi_comm_enable_o,
    output logic                    spi_param_enable_o,
    // i2c
    input  logic [`MMIO_DATA_W-1:0] i2c_xy_i,
    input  logic                    i2c_done_i
);

    chan_if mem_ch (); // router to memory master
    chan_if per_ch (); // router to spi/i2c bridge

    mmio_router router_i (
        .clk          (clk),
        .nRst         (nRst),
        .host_req_i   (host_req_i),
        .host_write_i (host_write_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .mem_ch       (mem_ch.master),
        .per_ch       (per_ch.master)
    );

    mem_bus_master mem_master_i (
        .clk         (clk),
        .nRst        (nRst),
        .ch          (mem_ch.slave),
        .mem_read_o  (mem_read_o),
        .mem_write_o (mem_write_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_busy_i  (mem_busy_i)
    );

    periph_bridge periph_i (
        .clk                (clk),
        .nRst               (nRst),
        .ch                 (per_ch.slave),
        .spi_busy_i         (spi_busy_i),
        .spi_data_o         (spi_data_o),
        .spi_comm_enable_o  (spi_comm_enable_o),
        .spi_param_enable_o (spi_param_enable_o),
        .i2c_xy_i           (i2c_xy_i),
        .i2c_done_i         (i2c_done_i)
    );

endmodule

//--- design/periph_bridge.sv
`include "mmio_cfg.svh"

module periph_bridge (
    input  logic                    clk,
    input  logic                    nRst,
    chan_if.slave                   ch,
    // spi display controller
    input  logic                    spi_busy_i,
    output logic [`MMIO_DATA_W-1:0] spi_data_o,
    output logic                    spi_comm_enable_o,
    output logic                    spi_param_enable_o,
    // i2c touch sensor
    input  logic [`MMIO_DATA_W-1:0] i2c_xy_i,
    input  logic                    i2c_done_i
);
    import mmio_pkg::*;

    periph_state_e           state;
    logic [`MMIO_DATA_W-1:0] i2c_xy_q;  // latest touch coordinate
    logic [`MMIO_DATA_W-1:0] rdata_q;
    logic                    new_req;   // req seen while idle
    logic                    cmd_wr;
    logic                    param_wr;
    logic                    i2c_rd;

    assign new_req  = (state == P_IDLE) & ch.req;
    assign cmd_wr   = ch.write & (ch.target == TGT_SPI_CMD);
    assign param_wr = ch.write & (ch.target == TGT_SPI_PARAM);
    assign i2c_rd   = ~ch.write & (ch.target == TGT_I2C);

    // wdata is held by the router for the whole access
    assign spi_data_o = ch.wdata;

    // parameter goes out straight away, no busy check
    assign spi_param_enable_o = new_req & param_wr;
    // command waits out spi busy
    assign spi_comm_enable_o  = (state == P_WAIT_SPI) & ~spi_busy_i;

    assign ch.ack   = (state == P_ACK);
    assign ch.rdata = rdata_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= P_IDLE;
        end else begin
            case (state)
                P_IDLE: begin
                    if (ch.req) begin
                        state <= cmd_wr ? P_WAIT_SPI : P_ACK;
                    end
                end
                P_WAIT_SPI: begin
                    if (!spi_busy_i) state <= P_ACK; // enable pulsed this cycle
                end
                P_ACK: begin
                    if (!ch.req) state <= P_IDLE;
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // touch capture, any done pulse updates it
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            i2c_xy_q <= '0;
        end else if (i2c_done_i) begin
            i2c_xy_q <= i2c_xy_i;
        end
    end

    // read word, i2c read returns the capture, everything else zero
    always_ff @(posedge clk) begin
        if (new_req) begin
            rdata_q <= i2c_rd ? i2c_xy_q : '0;
        end
    end

endmodule

//--- design/mem_bus_master.sv
`include "mmio_cfg.svh"

module mem_bus_master (
    input  logic                    clk,
    input  logic                    nRst,
    chan_if.slave                   ch,
    // data memory bus
    output logic                    mem_read_o,
    output logic                    mem_write_o,
    output logic [`MMIO_DATA_W-1:0] mem_addr_o,
    output logic [`MMIO_DATA_W-1:0] mem_wdata_o,
    input  logic [`MMIO_DATA_W-1:0] mem_rdata_i,
    input  logic                    mem_busy_i
);
    import mmio_pkg::*;

    mem_state_e              state;
    logic                    write_q;
    logic [`MMIO_DATA_W-1:0] addr_q;
    logic [`MMIO_DATA_W-1:0] wdata_q;
    logic [`MMIO_DATA_W-1:0] rdata_q;

    // single-cycle strobe while in STROBE
    assign mem_read_o  = (state == M_STROBE) & ~write_q;
    assign mem_write_o = (state == M_STROBE) & write_q;
    assign mem_addr_o  = addr_q;
    assign mem_wdata_o = wdata_q;

    assign ch.ack   = (state == M_ACK);
    assign ch.rdata = rdata_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= M_IDLE;
        end else begin
            case (state)
                M_IDLE:      if (ch.req) state <= M_STROBE;
                M_STROBE:    state <= M_WAIT_BUSY;
                // memory raises busy some time after the strobe
                M_WAIT_BUSY: if (mem_busy_i) state <= M_WAIT_DONE;
                M_WAIT_DONE: if (!mem_busy_i) state <= M_ACK;
                M_ACK:       if (!ch.req) state <= M_IDLE; // four-phase release
                default:     state <= M_IDLE;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (state == M_IDLE && ch.req) begin
            write_q <= ch.write;
            addr_q  <= ch.addr;
            wdata_q <= ch.wdata;
        end
        if (state == M_WAIT_DONE && !mem_busy_i) begin
            if (write_q || mem_rdata_i == `MMIO_POISON) begin
                rdata_q <= '0; // poison word reads as zero
            end else begin
                rdata_q <= mem_rdata_i;
            end
        end
    end

endmodule

//--- design/mmio_router.sv
`include "mmio_cfg.svh"

module mmio_router (
    input  logic                    clk,
    input  logic                    nRst,
    // host (memory handler) side
    input  logic                    host_req_i,
    input  logic                    host_write_i,
    input  logic [`MMIO_DATA_W-1:0] host_addr_i,
    input  logic [`MMIO_DATA_W-1:0] host_wdata_i,
    output logic                    host_ack_o,
    output logic [`MMIO_DATA_W-1:0] host_rdata_o,
    // channels
    chan_if.master                  mem_ch,
    chan_if.master                  per_ch
);
    import mmio_pkg::*;

    router_state_e           state;
    target_e                 tgt_dec;  // decode of live host address
    target_e                 tgt_q;    // target of the access in flight
    logic                    write_q;
    logic [`MMIO_DATA_W-1:0] addr_q;
    logic [`MMIO_DATA_W-1:0] wdata_q;
    logic [`MMIO_DATA_W-1:0] rdata_q;
    logic                    ch_req_q; // shared req steered by tgt_q
    logic                    ch_ack;
    logic [`MMIO_DATA_W-1:0] ch_rdata;

    // address decode
    always_comb begin
        if (host_addr_i < `MMIO_MEM_WORDS) begin
            tgt_dec = TGT_MEM;
        end else if (host_addr_i == `MMIO_SPI_CMD_ADDR) begin
            tgt_dec = TGT_SPI_CMD;
        end else if (host_addr_i == `MMIO_SPI_PARAM_ADDR) begin
            tgt_dec = TGT_SPI_PARAM;
        end else if (host_addr_i == `MMIO_I2C_ADDR) begin
            tgt_dec = TGT_I2C;
        end else begin
            tgt_dec = TGT_NONE; // unmapped
        end
    end

    // response merge from whichever channel acked
    assign ch_ack   = mem_ch.ack | per_ch.ack;
    assign ch_rdata = mem_ch.ack ? mem_ch.rdata : per_ch.rdata;

    // channel drive
    assign mem_ch.req    = ch_req_q & (tgt_q == TGT_MEM);
    assign mem_ch.write  = write_q;
    assign mem_ch.target = tgt_q;
    assign mem_ch.addr   = addr_q;
    assign mem_ch.wdata  = wdata_q;

    assign per_ch.req    = ch_req_q & (tgt_q != TGT_MEM); // never set for TGT_NONE
    assign per_ch.write  = write_q;
    assign per_ch.target = tgt_q;
    assign per_ch.addr   = addr_q;
    assign per_ch.wdata  = wdata_q;

    assign host_rdata_o = rdata_q;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state      <= R_IDLE;
            tgt_q      <= TGT_NONE;
            ch_req_q   <= 1'b0;
            host_ack_o <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (host_req_i) begin
                        tgt_q <= tgt_dec;
                        state <= R_DISPATCH;
                    end
                end
                R_DISPATCH: begin
                    ch_req_q <= (tgt_q != TGT_NONE); // unmapped skips the channel
                    state    <= R_RESPOND;
                end
                R_RESPOND: begin
                    if (tgt_q == TGT_NONE || ch_ack) begin
                        ch_req_q   <= 1'b0; // drop channel req with host ack
                        host_ack_o <= 1'b1;
                        state      <= R_RELEASE;
                    end
                end
                R_RELEASE: begin
                    if (!host_req_i) begin
                        host_ack_o <= 1'b0;
                        state      <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // access payload and response word
    always_ff @(posedge clk) begin
        if (state == R_IDLE && host_req_i) begin
            write_q <= host_write_i;
            addr_q  <= host_addr_i;
            wdata_q <= host_wdata_i;
        end
        if (state == R_RESPOND) begin
            if (tgt_q == TGT_NONE) begin
                rdata_q <= '0; // unmapped reads as zero
            end else if (ch_ack) begin
                rdata_q <= ch_rdata;
            end
        end
    end

endmodule

//--- design/chan_if.sv
`include "mmio_cfg.svh"

// one four-phase access between the router and a channel block
interface chan_if;
    import mmio_pkg::*;

    logic                    req;   // held until ack seen
    logic                    ack;   // held until req drops
    logic                    write;
    target_e                 target;
    logic [`MMIO_DATA_W-1:0] addr;
    logic [`MMIO_DATA_W-1:0] wdata;
    logic [`MMIO_DATA_W-1:0] rdata; // valid while ack high

    // router side
    modport master (
        output req, write, target, addr, wdata,
        input  ack, rdata
    );

    // channel block side
    modport slave (
        input  req, write, target, addr, wdata,
        output ack, rdata
    );

endinterface

//--- design/mmio_pkg.sv
package mmio_pkg;

    // where a host access ends up
    typedef enum logic [2:0] {
        TGT_NONE,      // unmapped, answered by the router itself
        TGT_MEM,       // data memory
        TGT_SPI_CMD,   // spi command register
        TGT_SPI_PARAM, // spi parameter register
        TGT_I2C        // i2c coordinate capture
    } target_e;

    // router sequencing
    typedef enum logic [1:0] {
        R_IDLE,     // wait for host req
        R_DISPATCH, // raise channel req
        R_RESPOND,  // wait for channel ack
        R_RELEASE   // hold host ack until req drops
    } router_state_e;

    // memory bus master
    typedef enum logic [2:0] {
        M_IDLE,
        M_STROBE,    // one cycle read/write strobe
        M_WAIT_BUSY, // memory has not started yet
        M_WAIT_DONE, // memory working
        M_ACK
    } mem_state_e;

    // peripheral bridge
    typedef enum logic [1:0] {
        P_IDLE,
        P_WAIT_SPI, // spi command held off by busy
        P_ACK
    } periph_state_e;

endpackage

//--- design/mmio_cfg.svh
`ifndef MMIO_CFG_SVH
`define MMIO_CFG_SVH

// bus width, shared by data and address
`define MMIO_DATA_W 32

// word addresses below this hit data memory
`define MMIO_MEM_WORDS 2048

// peripheral map
`define MMIO_SPI_CMD_ADDR   32'd121212 // spi command + counter
`define MMIO_SPI_PARAM_ADDR 32'd333333 // spi parameter word
`define MMIO_I2C_ADDR       32'd923923 // last touch coordinate

// memory returns this when the word is not valid
`define MMIO_POISON 32'hBAD1BAD1

`endif
